//--- bench/rom_subsystem_asserts.sv
/*
 * Handshake and busy checks, bound into every rom_download_ctrl.
 * Checks are off while rst_n is low.
 * dl_busy may trail the end of a handshake by one cycle.
 * fail_count holds the number of failed checks so far.
 */
`timescale 1ns/1ns

module rom_subsystem_asserts (
	input logic                       clk_sys,
	input logic                       rst_n,
	input logic                       dl_busy,
	input logic                       prog_req,
	input logic                       prog_ack,
	input rom_loader_pkg::prog_wr_t   prog_wr,
	input logic                       sprite_req,
	input logic                       sprite_ack,
	input rom_loader_pkg::sprite_wr_t sprite_wr
);
	logic hs_any;
	int   fail_count = 0;

	assign hs_any = prog_req || prog_ack || sprite_req || sprite_ack;

	// Req stays up until the store answers
	prog_req_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		prog_req && !prog_ack |=> prog_req)
		else begin
			$error("prog_req dropped before prog_ack");
			fail_count++;
		end
	sprite_req_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		sprite_req && !sprite_ack |=> sprite_req)
		else begin
			$error("sprite_req dropped before sprite_ack");
			fail_count++;
		end

	// Payload is frozen for the whole request
	prog_wr_stable: assert property (@(posedge clk_sys) disable iff (!rst_n)
		prog_req && $past(prog_req) |-> $stable(prog_wr))
		else begin
			$error("prog_wr changed while prog_req was high");
			fail_count++;
		end
	sprite_wr_stable: assert property (@(posedge clk_sys) disable iff (!rst_n)
		sprite_req && $past(sprite_req) |-> $stable(sprite_wr))
		else begin
			$error("sprite_wr changed while sprite_req was high");
			fail_count++;
		end

	busy_only_in_handshake: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!hs_any && !$past(hs_any) |-> !dl_busy)
		else begin
			$error("dl_busy high with no handshake in progress");
			fail_count++;
		end

endmodule

bind rom_download_ctrl rom_subsystem_asserts u_asserts (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.dl_busy    (dl_busy),
	.prog_req   (prog_req),
	.prog_ack   (prog_ack),
	.prog_wr    (prog_wr),
	.sprite_req (sprite_req),
	.sprite_ack (sprite_ack),
	.sprite_wr  (sprite_wr)
);

//--- bench/rom_subsystem_tb.sv
/*
 * Directed testbench for the ROM download and core reset subsystem.
 * Inputs change on the falling clock edge and outputs are sampled there.
 * Download bytes come from a 32-bit Galois LFSR; byte images of both
 * regions predict read data. Only written words are read back.
 * rom_ready is watched inside the controller by hierarchical name.
 */
`timescale 1ns/1ns

module rom_subsystem_tb;
	import rom_loader_pkg::*;

	localparam int byte_count  = 256 + 257 + 1 + 4;
	localparam int read_count  = 128 + 64 + 4 + 128 + 64;
	localparam int reset_allow = 6 * (second_reset_delay + 8);
	// Each byte also spends one cycle on the bus before busy rises
	localparam int margin      = byte_count + 200;
	localparam int cycle_limit = byte_count * 4 + read_count + reset_allow + margin;

	logic         clk_sys;
	logic         rst_n;
	logic         dl_active;
	logic         dl_wr;
	dl_addr_t     dl_addr;
	logic [7:0]   dl_data;
	logic         dl_busy;
	logic         user_reset;
	prog_addr_t   prog_rd_addr;
	prog_word_t   prog_rd_data;
	sprite_addr_t sprite_rd_addr;
	sprite_word_t sprite_rd_data;
	logic         core_reset;

	logic [7:0]  prog_img [prog_bytes];
	logic [7:0]  sprite_img [sprite_bytes];
	logic [31:0] lfsr;
	int          cycles = 0;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          errors_at_start;

	rom_subsystem_top DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: no result after %0d clock cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// ====================
	// Helpers
	// ====================
	function automatic logic [31:0] advance_lfsr(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic draw_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = advance_lfsr(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] got,
			input logic [31:0] exp);
		$display("Mismatch at %0t ns: %s is %h, expected %h", $time, sig, got, exp);
		errors++;
	endtask

	task automatic open_test();
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic close_test(input string name);
		if (errors == errors_at_start) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - errors_at_start);
			tests_failed++;
		end
	endtask

	// Entered and left just after a falling edge
	task automatic send_byte(input dl_addr_t addr, input logic [7:0] data);
		dl_wr   = 1'b1;
		dl_addr = addr;
		dl_data = data;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		while (dl_busy)
			@(negedge clk_sys);
	endtask

	task automatic load_random(input dl_addr_t addr);
		logic [7:0] b;
		draw_byte(b);
		send_byte(addr, b);
		if (addr < sprite_base)
			prog_img[addr - prog_base] = b;
		else
			sprite_img[addr - sprite_base] = b;
	endtask

	task automatic end_download();
		dl_active = 1'b0;
		@(negedge clk_sys);
		while (!DUT.u_ctrl.rom_ready)
			@(negedge clk_sys);
	endtask

	// Little-endian word from the byte image, read one cycle after the address
	task automatic compare_word(input bit sprite, input int w);
		logic [31:0] exp;
		if (sprite) begin
			sprite_rd_addr = sprite_addr_t'(w);
			exp = {sprite_img[4*w+3], sprite_img[4*w+2], sprite_img[4*w+1], sprite_img[4*w]};
		end else begin
			prog_rd_addr = prog_addr_t'(w);
			exp = {16'h0, prog_img[2*w+1], prog_img[2*w]};
		end
		@(negedge clk_sys);
		if (sprite && sprite_rd_data !== exp)
			report_mismatch($sformatf("sprite_rd_data word %0d", w), sprite_rd_data, exp);
		if (!sprite && {16'h0, prog_rd_data} !== exp)
			report_mismatch($sformatf("prog_rd_data word %0d", w), prog_rd_data, exp);
	endtask

	// Called on the falling edge before the hold condition is first seen clear
	task automatic verify_release_pulse();
		if (core_reset !== 1'b1)
			report_mismatch("core_reset before release", core_reset, 1);
		for (int i = 0; i < second_reset_delay; i++) begin
			@(negedge clk_sys);
			if (core_reset !== 1'b0)
				report_mismatch($sformatf("core_reset %0d after release", i), core_reset, 0);
		end
		@(negedge clk_sys);
		if (core_reset !== 1'b1)
			report_mismatch("core_reset second pulse", core_reset, 1);
		@(negedge clk_sys);
		if (core_reset !== 1'b0)
			report_mismatch("core_reset after second pulse", core_reset, 0);
	endtask

	// ====================
	// Tests
	// ====================
	task automatic check_after_reset();
		open_test();
		@(negedge clk_sys);
		if (dl_busy !== 1'b0)
			report_mismatch("dl_busy", dl_busy, 0);
		if (core_reset !== 1'b1)
			report_mismatch("core_reset", core_reset, 1);
		if (prog_rd_data !== '0)
			report_mismatch("prog_rd_data", prog_rd_data, 0);
		if (sprite_rd_data !== '0)
			report_mismatch("sprite_rd_data", sprite_rd_data, 0);
		close_test("reset values");
	endtask

	task automatic load_program();
		open_test();
		dl_active = 1'b1;
		for (int i = 0; i < 256; i++)
			load_random(prog_base + dl_addr_t'(i));
		end_download();
		for (int w = 0; w < 128; w++)
			compare_word(1'b0, w);
		close_test("program load and readback");
	endtask

	task automatic load_sprites();
		open_test();
		dl_active = 1'b1;
		for (int i = 0; i < 256; i++)
			load_random(sprite_base + dl_addr_t'(i));
		// Past the sprite region; a wrapped offset would land on word 0
		dl_wr   = 1'b1;
		dl_addr = sprite_base + sprite_bytes;
		dl_data = ~sprite_img[0];
		@(negedge clk_sys);
		dl_wr = 1'b0;
		if (dl_busy !== 1'b0)
			report_mismatch("dl_busy for out of range byte", dl_busy, 0);
		end_download();
		for (int w = 0; w < 64; w++)
			compare_word(1'b1, w);
		close_test("sprite load and readback");
	endtask

	task automatic busy_and_read_hold();
		prog_word_t   prog_hold;
		sprite_word_t sprite_hold;
		int           busy_cycles;
		open_test();
		compare_word(1'b1, 9);
		compare_word(1'b0, 5);
		prog_hold   = prog_rd_data;
		sprite_hold = sprite_rd_data;
		dl_active   = 1'b1;
		@(negedge clk_sys);
		prog_rd_addr   = prog_addr_t'(6);
		sprite_rd_addr = sprite_addr_t'(10);
		// Upper lane of program word 5
		draw_byte(prog_img[11]);
		dl_wr   = 1'b1;
		dl_addr = prog_base + 11;
		dl_data = prog_img[11];
		@(negedge clk_sys);
		dl_wr       = 1'b0;
		busy_cycles = 0;
		if (dl_busy !== 1'b1)
			report_mismatch("dl_busy one cycle after dl_wr", dl_busy, 1);
		while (dl_busy) begin
			busy_cycles++;
			@(negedge clk_sys);
		end
		if (busy_cycles != 4)
			report_mismatch("dl_busy high cycles", busy_cycles, 4);
		if (prog_rd_data !== prog_hold)
			report_mismatch("prog_rd_data held", prog_rd_data, prog_hold);
		if (sprite_rd_data !== sprite_hold)
			report_mismatch("sprite_rd_data held", sprite_rd_data, sprite_hold);
		end_download();
		compare_word(1'b0, 5);
		compare_word(1'b0, 6);
		close_test("back-pressure and read hold");
	endtask

	task automatic reset_sequence();
		open_test();
		dl_active = 1'b1;
		repeat (2) @(negedge clk_sys);
		for (int i = 0; i < 4; i++) begin
			if (core_reset !== 1'b1)
				report_mismatch("core_reset during download", core_reset, 1);
			load_random(prog_base + dl_addr_t'(400 + i));
		end
		end_download();
		verify_release_pulse();
		close_test("reset sequence");
	endtask

	task automatic apply_user_reset();
		open_test();
		user_reset = 1'b1;
		@(negedge clk_sys);
		if (core_reset !== 1'b1)
			report_mismatch("core_reset under user reset", core_reset, 1);
		repeat (3) @(negedge clk_sys);
		user_reset = 1'b0;
		verify_release_pulse();
		for (int w = 0; w < 128; w++)
			compare_word(1'b0, w);
		for (int w = 0; w < 64; w++)
			compare_word(1'b1, w);
		close_test("user reset");
	endtask

	initial begin
		rst_n          = 1'b0;
		dl_active      = 1'b0;
		dl_wr          = 1'b0;
		dl_addr        = '0;
		dl_data        = '0;
		user_reset     = 1'b0;
		prog_rd_addr   = '0;
		sprite_rd_addr = '0;
		lfsr           = 32'hb0c0d3c1;
		errors         = 0;
		tests_run      = 0;
		tests_failed   = 0;
		repeat (4) @(negedge clk_sys);
		rst_n = 1'b1;
		check_after_reset();
		load_program();
		load_sprites();
		busy_and_read_hold();
		reset_sequence();
		apply_user_reset();
		$display("Tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, DUT.u_ctrl.u_asserts.fail_count);
		if (errors == 0 && DUT.u_ctrl.u_asserts.fail_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- project.f
src/rom_loader_pkg.sv
src/rom_download_ctrl.sv
src/rom_store.sv
src/core_reset_gen.sv
src/rom_subsystem_top.sv
bench/rom_subsystem_asserts.sv
bench/rom_subsystem_tb.sv

//--- src/core_reset_gen.sv
/*
 * Core reset sequencer.
 * core_reset is held while user_reset is high or rom_ready is low, drops one
 * cycle after both clear, then pulses high for one cycle second_reset_delay
 * cycles after the drop. A new hold condition cancels a pending pulse.
 */
`timescale 1ns/1ns

module core_reset_gen (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic user_reset,
	input  logic rom_ready,
	output logic core_reset
);
	import rom_loader_pkg::*;

	logic                                      hold;
	logic                                      held;
	logic [$clog2(second_reset_delay+1)-1:0]   cnt;

	assign hold = user_reset || !rom_ready;

	// ====================
	// Second pulse counter
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			held <= 1'b1;
			cnt  <= '0;
		end else begin
			held <= hold;
			if (hold)
				cnt <= '0;
			else if (held)
				cnt <= $bits(cnt)'(second_reset_delay);  // first release
			else if (cnt != 0)
				cnt <= cnt - 1'b1;
		end
	end

	// Pulse fires on the edge where the count reaches one
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			core_reset <= 1'b1;
		else
			core_reset <= hold || (cnt == 1);
	end

endmodule

//--- src/rom_download_ctrl.sv
/*
 * Turns download bytes into single-lane store writes.
 * The host must not pulse dl_wr while dl_busy is high; such a pulse is ignored.
 * dl_wr is only honoured while dl_active is high.
 * Bytes outside both regions are dropped and never raise dl_busy.
 * rom_ready rises on the cycle after dl_active falls if any write has completed,
 * and stays high until the next download starts.
 */
`timescale 1ns/1ns

module rom_download_ctrl (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    dl_active,
	input  logic                    dl_wr,
	input  rom_loader_pkg::dl_addr_t dl_addr,
	input  logic [7:0]              dl_data,
	output logic                    dl_busy,
	output logic                    prog_req,
	output rom_loader_pkg::prog_wr_t prog_wr,
	input  logic                    prog_ack,
	output logic                    sprite_req,
	output rom_loader_pkg::sprite_wr_t sprite_wr,
	input  logic                    sprite_ack,
	output logic                    rom_ready
);
	import rom_loader_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_release
	} state_t;

	state_t       state;
	logic         sel_sprite;
	logic         written;
	logic         dl_active_d;
	dl_addr_t     prog_off;
	dl_addr_t     sprite_off;
	logic         hit_prog;
	logic         hit_sprite;
	logic         accept;
	logic         ack_sel;
	prog_wr_t     prog_next;
	sprite_wr_t   sprite_next;

	// ====================
	// Byte decode
	// ====================
	// Offsets below a region base wrap to large values and fail the range test
	assign prog_off   = dl_addr - prog_base;
	assign sprite_off = dl_addr - sprite_base;
	assign hit_prog   = prog_off < prog_bytes;
	assign hit_sprite = sprite_off < sprite_bytes;

	assign prog_next.addr   = prog_addr_t'(prog_off / prog_lanes);
	assign prog_next.mask   = prog_lanes'(1) << (prog_off % prog_lanes);
	assign prog_next.data   = {prog_lanes{dl_data}};

	assign sprite_next.addr = sprite_addr_t'(sprite_off / sprite_lanes);
	assign sprite_next.mask = sprite_lanes'(1) << (sprite_off % sprite_lanes);
	assign sprite_next.data = {sprite_lanes{dl_data}};

	assign accept  = dl_active && dl_wr && (hit_prog || hit_sprite);
	assign ack_sel = sel_sprite ? sprite_ack : prog_ack;

	// ====================
	// Handshake FSM
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state      <= st_idle;
			sel_sprite <= 1'b0;
			prog_req   <= 1'b0;
			sprite_req <= 1'b0;
			dl_busy    <= 1'b0;
			written    <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						sel_sprite <= hit_sprite;
						prog_req   <= hit_prog;
						sprite_req <= hit_sprite;
						dl_busy    <= 1'b1;
						state      <= st_req;
					end
				end
				st_req: begin
					// Store has written the lanes, start the release phase
					if (ack_sel) begin
						prog_req   <= 1'b0;
						sprite_req <= 1'b0;
						state      <= st_release;
					end
				end
				st_release: begin
					if (!ack_sel) begin
						dl_busy <= 1'b0;
						written <= 1'b1;
						state   <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Request payload, held while req is high
	always_ff @(posedge clk_sys) begin
		if (state == st_idle && accept) begin
			if (hit_prog)
				prog_wr <= prog_next;
			if (hit_sprite)
				sprite_wr <= sprite_next;
		end
	end

	// ====================
	// Load completion
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_active_d <= 1'b0;
			rom_ready   <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
			if (dl_active)
				rom_ready <= 1'b0;
			else if (dl_active_d)
				rom_ready <= written;  // falling edge of dl_active
		end
	end

endmodule

//--- src/rom_loader_pkg.sv
/*
 * Address map, store geometry and write-request types for the ROM loader.
 * The program region is 8 KiB from byte 0 and the sprite region is 4 KiB
 * right after it. Bytes above the sprite region are not stored.
 * Byte order is little-endian within each store word.
 * second_reset_delay is counted from the first release of core reset.
 */
package rom_loader_pkg;

	// ====================
	// Basic types
	// ====================
	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] prog_word_t;
	typedef logic [31:0] sprite_word_t;
	typedef logic [11:0] prog_addr_t;
	typedef logic [9:0]  sprite_addr_t;

	// ====================
	// Address map
	// ====================
	localparam dl_addr_t prog_base    = 25'd0;
	localparam dl_addr_t prog_bytes   = 25'd8192;
	localparam dl_addr_t sprite_base  = 25'd8192;
	localparam dl_addr_t sprite_bytes = 25'd4096;

	// Store geometry
	localparam int unsigned prog_depth   = 4096;
	localparam int unsigned sprite_depth = 1024;
	localparam int unsigned prog_lanes   = $bits(prog_word_t) / 8;
	localparam int unsigned sprite_lanes = $bits(sprite_word_t) / 8;

	// Cycles from core reset release to the extra one-cycle pulse
	localparam int unsigned second_reset_delay = 16;

	// ====================
	// Write requests
	// ====================
	// Data carries the download byte on every lane, the mask picks one
	typedef struct packed {
		prog_addr_t              addr;
		logic [prog_lanes-1:0]   mask;
		prog_word_t              data;
	} prog_wr_t;

	typedef struct packed {
		sprite_addr_t            addr;
		logic [sprite_lanes-1:0] mask;
		sprite_word_t            data;
	} sprite_wr_t;

endpackage

//--- src/rom_store.sv
/*
 * Word memory with byte-lane writes and one registered read port.
 * word_t must be a whole number of bytes; wr_t must carry addr, mask and data
 * fields, with one mask bit per byte lane.
 * Each rising req writes once; ack follows req with one cycle of delay.
 * The read register loads only while rd_en is high and clears on reset.
 * Memory contents are not cleared by reset.
 */
`timescale 1ns/1ns

module rom_store #(
	parameter type         word_t = rom_loader_pkg::prog_word_t,
	parameter type         wr_t   = rom_loader_pkg::prog_wr_t,
	parameter int unsigned depth  = 4096
) (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     req,
	input  wr_t                      wr,
	output logic                     ack,
	input  logic                     rd_en,
	input  logic [$clog2(depth)-1:0] rd_addr,
	output word_t                    rd_data
);

	// Storage split into byte lanes so each lane can be written on its own
	logic [$bits(word_t)/8-1:0][7:0] mem [depth];

	logic write_now;

	// ====================
	// Write port
	// ====================
	// Only the first cycle of a request writes
	assign write_now = req && !ack;

	always_ff @(posedge clk_sys) begin
		if (write_now) begin
			for (int i = 0; i < $bits(word_t) / 8; i++) begin
				if (wr.mask[i])
					mem[wr.addr][i] <= wr.data[i*8 +: 8];
			end
		end
	end

	// Ack mirrors req one cycle later, which gives both handshake phases
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			ack <= 1'b0;
		else
			ack <= req;
	end

	// ====================
	// Read port
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			rd_data <= '0;
		else if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

//--- src/rom_subsystem_top.sv
/*
 * ROM download and core reset subsystem.
 * One download controller feeds a 16-bit program store and a 32-bit sprite
 * store; reads are enabled only once the ROM is loaded.
 * Read data arrives one cycle after the address is sampled.
 */
`timescale 1ns/1ns

module rom_subsystem_top (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          dl_active,
	input  logic                          dl_wr,
	input  rom_loader_pkg::dl_addr_t      dl_addr,
	input  logic [7:0]                    dl_data,
	output logic                          dl_busy,
	input  logic                          user_reset,
	input  rom_loader_pkg::prog_addr_t    prog_rd_addr,
	output rom_loader_pkg::prog_word_t    prog_rd_data,
	input  rom_loader_pkg::sprite_addr_t  sprite_rd_addr,
	output rom_loader_pkg::sprite_word_t  sprite_rd_data,
	output logic                          core_reset
);
	import rom_loader_pkg::*;

	logic       prog_req;
	logic       prog_ack;
	prog_wr_t   prog_wr;
	logic       sprite_req;
	logic       sprite_ack;
	sprite_wr_t sprite_wr;
	logic       rom_ready;

	// ====================
	// Download path
	// ====================
	rom_download_ctrl u_ctrl (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.dl_busy    (dl_busy),
		.prog_req   (prog_req),
		.prog_wr    (prog_wr),
		.prog_ack   (prog_ack),
		.sprite_req (sprite_req),
		.sprite_wr  (sprite_wr),
		.sprite_ack (sprite_ack),
		.rom_ready  (rom_ready)
	);

	// ====================
	// Stores
	// ====================
	rom_store #(
		.word_t (prog_word_t),
		.wr_t   (prog_wr_t),
		.depth  (prog_depth)
	) prog_store (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.req     (prog_req),
		.wr      (prog_wr),
		.ack     (prog_ack),
		.rd_en   (rom_ready),
		.rd_addr (prog_rd_addr),
		.rd_data (prog_rd_data)
	);

	rom_store #(
		.word_t (sprite_word_t),
		.wr_t   (sprite_wr_t),
		.depth  (sprite_depth)
	) sprite_store (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.req     (sprite_req),
		.wr      (sprite_wr),
		.ack     (sprite_ack),
		.rd_en   (rom_ready),
		.rd_addr (sprite_rd_addr),
		.rd_data (sprite_rd_data)
	);

	// Game core reset
	core_reset_gen u_reset (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.user_reset (user_reset),
		.rom_ready  (rom_ready),
		.core_reset (core_reset)
	);

endmodule
